//--- hdl/gbTimer_cfg.svh
`ifndef GB_TIMER_CFG_SVH
`define GB_TIMER_CFG_SVH

// ------------------------------------------------------------
// Machine-cycle counter and divider
// ------------------------------------------------------------

// Free-running machine-cycle counter width
`define GB_CNT_WIDTH 14

// DIV is the top byte of the counter, one step per 64 cycles
`define GB_DIV_MSB 13
`define GB_DIV_LSB 6

// ------------------------------------------------------------
// TAC layout and TIMA speed taps
// ------------------------------------------------------------

// Falling edge of the tap bit gives one TIMA step
`define GB_TAP_SPEED0 7
`define GB_TAP_SPEED1 1
`define GB_TAP_SPEED2 3
`define GB_TAP_SPEED3 5
`define GB_TAC_RUN_BIT 2

// Width of a machine-cycle cost
`define GB_COST_W 3

`endif

//--- hdl/gbTimerPkg.sv
`include "gbTimer_cfg.svh"

package gbTimerPkg;

    // ------------------------------------------------------------
    // Register select on the write port
    // ------------------------------------------------------------
    typedef enum logic [1:0]
    {
        selDiv  = 2'd0,
        selTima = 2'd1,
        selTma  = 2'd2,
        selTac  = 2'd3
    } timerRegSelT;

    // Tick tracker states
    typedef enum logic [1:0]
    {
        idle        = 2'd0,
        branchArmed = 2'd1,
        draining    = 2'd2
    } tickStateT;

    // Machine-cycle count of one instruction
    typedef logic [`GB_COST_W-1:0] costT;

    // Decoded cost of the current opcode
    typedef struct packed
    {
        costT cycles;       // Not-taken cost
        costT takenCycles;  // Cost when a conditional branch is taken
        logic condBranch;
        logic cbOp;
    } instrCostT;

    // Direct register write
    typedef struct packed
    {
        logic        en;
        timerRegSelT sel;
        logic [7:0]  data;
    } regWriteT;

    // Register read view, DIV in the top byte
    typedef struct packed
    {
        logic [7:0] div;
        logic [7:0] tima;
        logic [7:0] tma;
        logic [7:0] tac;
    } timerRegsT;

endpackage

//--- hdl/cycleCostDecoder.sv
`timescale 1ns/1ps
`include "gbTimer_cfg.svh"

module cycleCostDecoder
    import gbTimerPkg::*;
(
    input  logic [7:0] opcode,
    input  logic       cbPrefix,
    output instrCostT  cost
);

    // ------------------------------------------------------------
    // Not-taken cost tables
    // ------------------------------------------------------------
    // One row per high nibble, one hex digit per low nibble
    // Leftmost digit is low nibble 0
    // Digit 0 marks an undefined opcode or the bare CB prefix
    localparam logic [63:0] BASE_ROW [16] = '{
        64'h1322_1121_5222_1121,    // 0x: 16-bit loads, LD (nn),SP
        64'h1322_1121_3222_1121,    // 1x: JR n is unconditional
        64'h2322_1121_2222_1121,    // 2x: JR NZ / JR Z
        64'h2322_3331_2222_1121,    // 3x: INC/DEC (HL), LD (HL),n
        64'h1111_1121_1111_1121,    // 4x
        64'h1111_1121_1111_1121,    // 5x
        64'h1111_1121_1111_1121,    // 6x
        64'h2222_2212_1111_1121,    // 7x: stores to (HL), HALT
        64'h1111_1121_1111_1121,    // 8x: ALU block
        64'h1111_1121_1111_1121,    // 9x
        64'h1111_1121_1111_1121,    // Ax
        64'h1111_1121_1111_1121,    // Bx
        64'h2334_3424_2430_3624,    // Cx: RET, JP, CALL, RST
        64'h2330_3424_2430_3024,    // Dx
        64'h3320_0424_4140_0024,    // Ex: LDH, ADD SP,n
        64'h3321_0424_3241_0024     // Fx
    };

    // CB table, register operand 2, (HL) operand 4, BIT on (HL) 3
    localparam logic [63:0] CB_ROW [16] = '{
        64'h2222_2242_2222_2242,    // Rotates
        64'h2222_2242_2222_2242,
        64'h2222_2242_2222_2242,    // Shifts
        64'h2222_2242_2222_2242,    // SWAP, SRL
        64'h2222_2232_2222_2232,    // BIT only reads (HL)
        64'h2222_2232_2222_2232,
        64'h2222_2232_2222_2232,
        64'h2222_2232_2222_2232,
        64'h2222_2242_2222_2242,    // RES
        64'h2222_2242_2222_2242,
        64'h2222_2242_2222_2242,
        64'h2222_2242_2222_2242,
        64'h2222_2242_2222_2242,    // SET
        64'h2222_2242_2222_2242,
        64'h2222_2242_2222_2242,
        64'h2222_2242_2222_2242
    };

    logic [63:0] costRow;
    logic [3:0]  costDigit;
    logic [3:0]  colIdx;

    // ------------------------------------------------------------
    // Table lookup
    // ------------------------------------------------------------
    always_comb
    begin
        // Row from high nibble, CB prefix switches tables
        costRow = cbPrefix ? CB_ROW[opcode[7:4]] : BASE_ROW[opcode[7:4]];

        // Low nibble 0 sits in the top digit
        colIdx    = 4'd15 - opcode[3:0];
        costDigit = costRow[colIdx*4 +: 4];
    end

    // ------------------------------------------------------------
    // Conditional branches and their taken cost
    // ------------------------------------------------------------
    always_comb
    begin
        cost.cycles      = costDigit[`GB_COST_W-1:0];
        cost.takenCycles = costDigit[`GB_COST_W-1:0];
        cost.condBranch  = 1'b0;
        cost.cbOp        = cbPrefix;

        // No branches in the CB space
        if (!cbPrefix)
        begin
            case (opcode)
                // JR cc
                8'h20, 8'h28, 8'h30, 8'h38:
                begin
                    cost.condBranch  = 1'b1;
                    cost.takenCycles = costT'(3);
                end
                // JP cc
                8'hC2, 8'hCA, 8'hD2, 8'hDA:
                begin
                    cost.condBranch  = 1'b1;
                    cost.takenCycles = costT'(4);
                end
                // CALL cc pushes the return address when taken
                8'hC4, 8'hCC, 8'hD4, 8'hDC:
                begin
                    cost.condBranch  = 1'b1;
                    cost.takenCycles = costT'(6);
                end
                // RET cc
                8'hC0, 8'hC8, 8'hD0, 8'hD8:
                begin
                    cost.condBranch  = 1'b1;
                    cost.takenCycles = costT'(5);
                end
                default:
                begin
                    cost.condBranch = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- hdl/instrTickTracker.sv
`timescale 1ns/1ps

module instrTickTracker
    import gbTimerPkg::*;
(
    input  logic      iClock,
    input  logic      rstN,
    input  instrCostT cost,
    input  logic      branchTaken,
    input  logic      eof,
    output logic      machineCycle
);

    tickStateT state;
    tickStateT stateNext;
    costT      pending;
    costT      pendingNext;
    costT      loadCycles;
    logic      takenHeld;
    logic      takenHeldNext;
    logic      takenNow;

    // ------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------
    always_comb
    begin
        // Strobe on the eof clock still counts for this instruction
        takenNow = takenHeld | branchTaken;

        // Taken cost only for a conditional branch that was taken
        if (cost.condBranch && !cost.cbOp && takenNow)
            loadCycles = cost.takenCycles;
        else
            loadCycles = cost.cycles;

        stateNext     = state;
        pendingNext   = pending;
        takenHeldNext = takenNow;

        if (eof)
        begin
            // New burst, may chain onto the last strobe of the old one
            pendingNext   = loadCycles;
            takenHeldNext = 1'b0;
            stateNext     = (loadCycles != '0) ? draining : idle;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (branchTaken)
                        stateNext = branchArmed;
                end
                branchArmed:
                begin
                    // Wait for eof with the taken flag held
                    stateNext = branchArmed;
                end
                draining:
                begin
                    pendingNext = pending - costT'(1);
                    // Last strobe, keep a taken strobe for the next one
                    if (pending == costT'(1))
                        stateNext = takenNow ? branchArmed : idle;
                end
                default:
                begin
                    stateNext = idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------
    always_ff @(posedge iClock or negedge rstN)
    begin
        if (!rstN)
        begin
            state     <= idle;
            pending   <= '0;
            takenHeld <= 1'b0;
        end
        else
        begin
            state     <= stateNext;
            pending   <= pendingNext;
            takenHeld <= takenHeldNext;
        end
    end

    // One strobe per clock while draining
    assign machineCycle = (state == draining);

endmodule

//--- hdl/timerRegs.sv
`timescale 1ns/1ps
`include "gbTimer_cfg.svh"

module timerRegs
    import gbTimerPkg::*;
(
    input  logic      iClock,
    input  logic      rstN,
    input  logic      machineCycle,
    input  regWriteT  regWrite,
    output timerRegsT regs,
    output logic      timerIrq
);

    logic [`GB_CNT_WIDTH-1:0] cycleCount;
    logic [`GB_CNT_WIDTH-1:0] cycleCountNext;
    logic [7:0]               tima;
    logic [7:0]               tma;
    logic [2:0]               tac;
    logic                     divWrite;
    logic                     timaWrite;
    logic                     tmaWrite;
    logic                     tacWrite;
    logic                     tapOld;
    logic                     tapNew;
    logic                     timaStep;
    logic                     overflow;

    // ------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------
    assign divWrite  = regWrite.en && (regWrite.sel == selDiv);
    assign timaWrite = regWrite.en && (regWrite.sel == selTima);
    assign tmaWrite  = regWrite.en && (regWrite.sel == selTma);
    assign tacWrite  = regWrite.en && (regWrite.sel == selTac);

    // Counter clear wins over a pending increment
    always_comb
    begin
        if (divWrite)
            cycleCountNext = '0;
        else if (machineCycle)
            cycleCountNext = cycleCount + 1'b1;
        else
            cycleCountNext = cycleCount;
    end

    // ------------------------------------------------------------
    // TIMA step from the selected tap
    // ------------------------------------------------------------
    always_comb
    begin
        case (tac[1:0])
            2'b00:
            begin
                tapOld = cycleCount[`GB_TAP_SPEED0];
                tapNew = cycleCountNext[`GB_TAP_SPEED0];
            end
            2'b01:
            begin
                tapOld = cycleCount[`GB_TAP_SPEED1];
                tapNew = cycleCountNext[`GB_TAP_SPEED1];
            end
            2'b10:
            begin
                tapOld = cycleCount[`GB_TAP_SPEED2];
                tapNew = cycleCountNext[`GB_TAP_SPEED2];
            end
            default:
            begin
                tapOld = cycleCount[`GB_TAP_SPEED3];
                tapNew = cycleCountNext[`GB_TAP_SPEED3];
            end
        endcase
    end

    // Falling tap edge, also from a DIV clear
    assign timaStep = tac[`GB_TAC_RUN_BIT] && tapOld && !tapNew;
    assign overflow = timaStep && (tima == 8'hFF);

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------
    always_ff @(posedge iClock or negedge rstN)
    begin
        if (!rstN)
        begin
            cycleCount <= '0;
            tima       <= 8'd0;
            tma        <= 8'd0;
            tac        <= 3'd0;
            timerIrq   <= 1'b0;
        end
        else
        begin
            cycleCount <= cycleCountNext;

            // A TIMA write drops the reload and the interrupt
            timerIrq <= overflow && !timaWrite;

            if (timaWrite)
                tima <= regWrite.data;
            else if (overflow)
                tima <= tma;
            else if (timaStep)
                tima <= tima + 8'd1;

            if (tmaWrite)
                tma <= regWrite.data;

            // Only speed and run bits are stored
            if (tacWrite)
                tac <= regWrite.data[2:0];
        end
    end

    // Read view
    assign regs.div  = cycleCount[`GB_DIV_MSB:`GB_DIV_LSB];
    assign regs.tima = tima;
    assign regs.tma  = tma;
    assign regs.tac  = {5'd0, tac};

endmodule

//--- hdl/gbTimer.sv
`timescale 1ns/1ps

module gbTimer
    import gbTimerPkg::*;
(
    input  logic       iClock,
    input  logic       rstN,
    input  logic [7:0] opcode,
    input  logic       cbPrefix,
    input  logic       branchTaken,
    input  logic       eof,
    input  regWriteT   regWrite,
    output timerRegsT  regs,
    output logic       machineCycle,
    output logic       timerIrq
);

    // Cost of the instruction in flight
    instrCostT cost;

    // ------------------------------------------------------------
    // Opcode cost lookup
    // ------------------------------------------------------------
    cycleCostDecoder costDecoder (
        .opcode   (opcode),
        .cbPrefix (cbPrefix),
        .cost     (cost)
    );

    // End of instruction to machine-cycle burst
    instrTickTracker tickTracker (
        .iClock       (iClock),
        .rstN         (rstN),
        .cost         (cost),
        .branchTaken  (branchTaken),
        .eof          (eof),
        .machineCycle (machineCycle)
    );

    // DIV, TIMA, TMA, TAC and the overflow interrupt
    timerRegs regBlock (
        .iClock       (iClock),
        .rstN         (rstN),
        .machineCycle (machineCycle),
        .regWrite     (regWrite),
        .regs         (regs),
        .timerIrq     (timerIrq)
    );

endmodule

//--- test/gbTimer_sva.sv
`timescale 1ns/1ps

module gbTimerSva
    import gbTimerPkg::*;
(
    input logic iClock,
    input logic rstN,
    input logic eof,
    input costT pending,
    input logic machineCycle,
    input logic timerIrq
);

    // Failures so far, read back by the testbench
    int failCount = 0;

    // ------------------------------------------------------------
    // Tracker spacing and register pulses
    // ------------------------------------------------------------

    // Next eof no earlier than the last strobe of a burst
    eofSpacing: assert property (@(posedge iClock) disable iff (!rstN)
        eof |-> (pending <= costT'(1)))
    else
    begin
        failCount++;
        $error("eof arrived with more than one strobe pending");
    end

    // Overflow interrupt is a single clock
    irqOneClock: assert property (@(posedge iClock) disable iff (!rstN)
        timerIrq |=> !timerIrq)
    else
    begin
        failCount++;
        $error("timerIrq stayed high for more than one clock");
    end

    // Quiet outputs while reset is held
    quietInReset: assert property (@(posedge iClock)
        !rstN |-> (!machineCycle && !timerIrq))
    else
    begin
        failCount++;
        $error("machineCycle or timerIrq high during reset");
    end

endmodule

// Tracker has no interrupt
bind instrTickTracker gbTimerSva trackerChecks (
    .iClock       (iClock),
    .rstN         (rstN),
    .eof          (eof),
    .pending      (pending),
    .machineCycle (machineCycle),
    .timerIrq     (1'b0)
);

// Register block sees no eof
bind timerRegs gbTimerSva regChecks (
    .iClock       (iClock),
    .rstN         (rstN),
    .eof          (1'b0),
    .pending      ('0),
    .machineCycle (machineCycle),
    .timerIrq     (timerIrq)
);

//--- test/gbTimerTb.sv
`timescale 1ns/1ps
`include "gbTimer_cfg.svh"

module gbTimerTb
    import gbTimerPkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DIV_PERIOD   = 1 << `GB_DIV_LSB;
    localparam int RUN_TAC      = 1 << `GB_TAC_RUN_BIT;

    // TIMA step period per TAC speed code
    localparam int SPEED_PERIOD [4] = '{256, 4, 16, 64};

    // Cycle budget per test, each instruction takes at most about 14 clocks
    localparam int INSTR_CYCLES  = 40 * 14;
    localparam int BRANCH_CYCLES = 16 * 4 * 14;
    localparam int DIV_CYCLES    = 4 * DIV_PERIOD + 60;
    localparam int TIMA_CYCLES   = 2 * (256 + 4 + 16 + 64) + 200;
    localparam int OVF_CYCLES    = 80;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + 20 + INSTR_CYCLES + BRANCH_CYCLES
                                   + DIV_CYCLES + TIMA_CYCLES + OVF_CYCLES + 500;

    // Opcode classes
    localparam logic [7:0] ONE_OPS [8] = '{8'h00, 8'h41, 8'h52, 8'h63,
                                           8'h7B, 8'h48, 8'h5F, 8'h44};
    localparam logic [7:0] TWO_OPS [8] = '{8'h46, 8'h7E, 8'h86, 8'h96,
                                           8'hBE, 8'hC6, 8'hFE, 8'h70};
    localparam logic [7:0] BRANCH_OPS [16] = '{8'h20, 8'h28, 8'h30, 8'h38,
                                               8'hC2, 8'hCA, 8'hD2, 8'hDA,
                                               8'hC4, 8'hCC, 8'hD4, 8'hDC,
                                               8'hC0, 8'hC8, 8'hD0, 8'hD8};

    logic        iClock;
    logic        rstN;
    logic [7:0]  opcode;
    logic        cbPrefix;
    logic        branchTaken;
    logic        eof;
    regWriteT    regWrite;
    timerRegsT   regs;
    logic        machineCycle;
    logic        timerIrq;

    logic [31:0] lfsr;
    int          clockCount;
    int          mcPulses;
    int          irqPulses;
    int          svaFails;

    gbTimer uut (
        .iClock       (iClock),
        .rstN         (rstN),
        .opcode       (opcode),
        .cbPrefix     (cbPrefix),
        .branchTaken  (branchTaken),
        .eof          (eof),
        .regWrite     (regWrite),
        .regs         (regs),
        .machineCycle (machineCycle),
        .timerIrq     (timerIrq)
    );

    initial iClock = 1'b0;
    always #(CLK_PERIOD / 2) iClock = ~iClock;

    // ------------------------------------------------------------
    // Pulse monitors, assertion watch and run limit
    // ------------------------------------------------------------
    always @(posedge iClock)
    begin
        clockCount++;
        if (machineCycle === 1'b1)
            mcPulses++;
        if (timerIrq === 1'b1)
            irqPulses++;
        svaFails = uut.tickTracker.trackerChecks.failCount
                   + uut.regBlock.regChecks.failCount;
        if (svaFails != 0)
        begin
            $display("A bound assertion failed, see the assertion error above");
            $display("Finished with errors");
            $fatal(1);
        end
        else if (clockCount > CYCLE_LIMIT)
        begin
            $display("Timeout: the run passed %0d clock cycles without finishing", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic nextBit();
        logic bitOut;
        bitOut = lfsr[0];
        lfsr   = lfsr >> 1;
        if (bitOut)
            lfsr = lfsr ^ 32'h80200003;
        return bitOut;
    endfunction

    function automatic logic [7:0] randBits(input int n);
        logic [7:0] value;
        int         i;
        value = '0;
        for (i = 0; i < n; i++)
            value = {value[6:0], nextBit()};
        return value;
    endfunction

    // CB space: register operand 2, (HL) operand 4, BIT on (HL) 3
    function automatic int cbCycles(input logic [7:0] op);
        if (op[2:0] != 3'd6)
            return 2;
        else if (op[7:6] == 2'b01)
            return 3;
        else
            return 4;
    endfunction

    // Conditional branches, taken and not taken
    function automatic int condBranchCycles(input logic [7:0] op, input logic taken);
        case (op)
            8'h20, 8'h28, 8'h30, 8'h38: return taken ? 3 : 2;
            8'hC2, 8'hCA, 8'hD2, 8'hDA: return taken ? 4 : 3;
            8'hC4, 8'hCC, 8'hD4, 8'hDC: return taken ? 6 : 3;
            default: return taken ? 5 : 2;
        endcase
    endfunction

    function automatic timerRegsT packRegs(input int div, input int tima, input int tma,
                                           input int tac);
        timerRegsT value;
        value.div  = 8'(div);
        value.tima = 8'(tima);
        value.tma  = 8'(tma);
        value.tac  = 8'(tac);
        return value;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic stopOnError();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkRegs(input timerRegsT expected, input string what);
        if (regs !== expected)
        begin
            $display("ERR %0t: %s, regs expected %h_%h_%h_%h got %h_%h_%h_%h", $time, what,
                     expected.div, expected.tima, expected.tma, expected.tac,
                     regs.div, regs.tima, regs.tma, regs.tac);
            stopOnError();
        end
    endtask

    task automatic checkIrq(input logic expected, input string what);
        if (timerIrq !== expected)
        begin
            $display("ERR %0t: %s, timerIrq expected %b got %b", $time, what,
                     expected, timerIrq);
            stopOnError();
        end
    endtask

    task automatic checkCount(input int expected, input int actual, input string what);
        if (actual != expected)
        begin
            $display("ERR %0t: %s, expected %0d got %0d", $time, what, expected, actual);
            stopOnError();
        end
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------
    task automatic writeReg(input timerRegSelT sel, input logic [7:0] data);
        @(negedge iClock);
        regWrite = '{en: 1'b1, sel: sel, data: data};
        @(negedge iClock);
        regWrite.en = 1'b0;
    endtask

    // Back-to-back NOPs, one strobe each
    task automatic runNops(input int n);
        @(negedge iClock);
        opcode   = 8'h00;
        cbPrefix = 1'b0;
        eof      = 1'b1;
        repeat (n) @(negedge iClock);
        eof = 1'b0;
        // Last strobe of the chain
        @(negedge iClock);
    endtask

    // Mode 0 no branch strobe, 1 strobe before eof, 2 strobe with eof
    task automatic runInstr(input logic [7:0] op, input logic cb, input int takenMode,
                            input int expected);
        int    strobes;
        int    startPulses;
        string what;
        strobes     = 0;
        startPulses = mcPulses;
        what        = $sformatf("opcode %h cb %0d mode %0d", op, cb, takenMode);
        @(negedge iClock);
        opcode   = op;
        cbPrefix = cb;
        if (takenMode == 1)
        begin
            branchTaken = 1'b1;
            @(negedge iClock);
            branchTaken = 1'b0;
        end
        eof         = 1'b1;
        branchTaken = (takenMode == 2);
        @(negedge iClock);
        eof         = 1'b0;
        branchTaken = 1'b0;
        // Burst starts on the clock after eof and runs unbroken
        while (machineCycle === 1'b1 && strobes < 8)
        begin
            strobes++;
            @(negedge iClock);
        end
        checkCount(expected, strobes, {what, " burst length"});
        repeat (2) @(negedge iClock);
        checkCount(expected, mcPulses - startPulses, {what, " total strobes"});
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic resetDefaults();
        int startPulses;
        int startIrq;
        startPulses = mcPulses;
        startIrq    = irqPulses;
        checkRegs('0, "registers after reset");
        checkIrq(1'b0, "interrupt after reset");
        repeat (8) @(negedge iClock);
        checkCount(0, mcPulses - startPulses, "strobes with eof low");
        checkCount(0, irqPulses - startIrq, "interrupts with eof low");
        checkIrq(1'b0, "interrupt while idle");
    endtask

    task automatic opcodeCosts();
        logic [7:0] op;
        int         i;
        for (i = 0; i < 8; i++)
            runInstr(ONE_OPS[randBits(3)], 1'b0, 0, 1);
        for (i = 0; i < 8; i++)
            runInstr(TWO_OPS[randBits(3)], 1'b0, 0, 2);
        // JP nn, CALL nn, RET, then an undefined opcode
        runInstr(8'hC3, 1'b0, 0, 4);
        runInstr(8'hCD, 1'b0, 0, 6);
        runInstr(8'hC9, 1'b0, 0, 4);
        runInstr(8'hD3, 1'b0, 0, 0);
        for (i = 0; i < 16; i++)
        begin
            op = randBits(8);
            runInstr(op, 1'b1, 0, cbCycles(op));
        end
    endtask

    task automatic branchCosts();
        logic [7:0] op;
        logic       taken;
        int         mode;
        int         i;
        for (i = 0; i < 16; i++)
        begin
            op = BRANCH_OPS[i];
            runInstr(op, 1'b0, 0, condBranchCycles(op, 1'b0));
            runInstr(op, 1'b0, 1, condBranchCycles(op, 1'b1));
            runInstr(op, 1'b0, 2, condBranchCycles(op, 1'b1));
            taken = nextBit();
            mode  = taken ? (nextBit() ? 1 : 2) : 0;
            runInstr(op, 1'b0, mode, condBranchCycles(op, taken));
        end
    endtask

    task automatic dividerCount();
        // Any data clears the divider
        writeReg(selDiv, 8'h5C);
        checkRegs(packRegs(0, 0, 0, 0), "DIV after clear");
        runNops(DIV_PERIOD - 1);
        checkRegs(packRegs(0, 0, 0, 0), "DIV one cycle short");
        runNops(1);
        checkRegs(packRegs(1, 0, 0, 0), "DIV after one period");
        runNops(DIV_PERIOD);
        checkRegs(packRegs(2, 0, 0, 0), "DIV after two periods");
        writeReg(selDiv, 8'h00);
        checkRegs(packRegs(0, 0, 0, 0), "DIV after second clear");
        runNops(10);
        checkRegs(packRegs(0, 0, 0, 0), "DIV shortly after clear");
        runNops(DIV_PERIOD - 10);
        checkRegs(packRegs(1, 0, 0, 0), "DIV restarted count");
    endtask

    task automatic timaSpeeds();
        int s;
        int p;
        for (s = 0; s < 4; s++)
        begin
            p = SPEED_PERIOD[s];
            writeReg(selTac, 8'(RUN_TAC + s));
            // Clearing DIV may step TIMA, so TIMA is preset after it
            writeReg(selDiv, 8'h00);
            writeReg(selTima, 8'h00);
            runNops(p - 1);
            checkRegs(packRegs((p - 1) / DIV_PERIOD, 0, 0, RUN_TAC + s), "TIMA before step");
            runNops(1);
            checkRegs(packRegs(p / DIV_PERIOD, 1, 0, RUN_TAC + s), "TIMA first step");
            runNops(p);
            checkRegs(packRegs(2 * p / DIV_PERIOD, 2, 0, RUN_TAC + s), "TIMA second step");
        end
        // Run bit clear holds TIMA
        writeReg(selTac, 8'h01);
        writeReg(selDiv, 8'h00);
        writeReg(selTima, 8'h40);
        runNops(20);
        checkRegs(packRegs(0, 8'h40, 0, 1), "TIMA with run bit clear");
    endtask

    task automatic timaOverflow();
        int startIrq;
        writeReg(selTac, 8'(RUN_TAC + 1));
        writeReg(selTma, 8'h5A);
        writeReg(selDiv, 8'h00);
        writeReg(selTima, 8'hFE);
        startIrq = irqPulses;
        runNops(4);
        checkRegs(packRegs(0, 8'hFF, 8'h5A, RUN_TAC + 1), "TIMA one step before overflow");
        checkCount(0, irqPulses - startIrq, "interrupts before overflow");
        runNops(4);
        checkRegs(packRegs(0, 8'h5A, 8'h5A, RUN_TAC + 1), "TIMA reload from TMA");
        checkIrq(1'b1, "interrupt on overflow");
        @(negedge iClock);
        checkIrq(1'b0, "interrupt one clock later");
        checkCount(1, irqPulses - startIrq, "interrupt pulses");
        // Count is now 8, three more puts the next step on a strobe
        runNops(3);
        @(negedge iClock);
        eof = 1'b1;
        @(negedge iClock);
        // Strobe is high here and the tap falls at count 12
        eof      = 1'b0;
        regWrite = '{en: 1'b1, sel: selTima, data: 8'h33};
        @(negedge iClock);
        regWrite.en = 1'b0;
        checkRegs(packRegs(0, 8'h33, 8'h5A, RUN_TAC + 1), "TIMA write over a step");
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        lfsr        = 32'h3874;
        clockCount  = 0;
        mcPulses    = 0;
        irqPulses   = 0;
        rstN        = 1'b0;
        opcode      = 8'h00;
        cbPrefix    = 1'b0;
        branchTaken = 1'b0;
        eof         = 1'b0;
        regWrite    = '0;
        repeat (RESET_CYCLES) @(negedge iClock);
        rstN = 1'b1;

        resetDefaults();
        opcodeCosts();
        branchCosts();
        dividerCount();
        timaSpeeds();
        timaOverflow();

        // Assertion failures from both bound checkers
        svaFails = uut.tickTracker.trackerChecks.failCount
                   + uut.regBlock.regChecks.failCount;
        if (svaFails == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- list.f
+incdir+hdl
hdl/gbTimerPkg.sv
hdl/cycleCostDecoder.sv
hdl/instrTickTracker.sv
hdl/timerRegs.sv
hdl/gbTimer.sv
test/gbTimer_sva.sv
test/gbTimerTb.sv
